//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_aluSystem
RTL_TOP    := aluSystem
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src.f
verilog/aluPkg.sv
verilog/datapathPkg.sv
verilog/regBank.sv
verilog/alu.sv
verilog/dataMemory.sv
verilog/aluSystem.sv
testbench/tb_aluSystem.sv

//--- testbench/aluSystem_golden.txt
// rst gWe gWs gFn gRa gRb aWe aWs aFn aRc aRd srcA srcB aluA fun flagEn memWr memRd imm
// name expAluOut expFlags(ZCNO) expMemOut expAddr, all values hex
0 1 0 2 0 1 0 0 0 0 0 0 1 1 0 0 0 0 12 ldG0 12 0 00 00
0 1 1 2 0 1 0 0 0 0 0 0 1 1 1 0 0 0 34 ldG1 34 0 00 00
0 1 2 2 2 3 0 0 0 0 0 0 1 1 0 0 0 0 7f ldG2 7f 0 00 00
0 1 3 2 2 3 0 0 0 0 0 0 1 1 1 0 0 0 ff ldG3 ff 0 00 00
0 1 0 1 0 1 0 0 0 0 0 0 1 1 0 0 0 0 00 incG0 13 0 00 00
0 1 3 1 3 1 0 0 0 0 0 0 1 1 0 0 0 0 00 incG3Wrap 00 0 00 00
0 1 1 0 0 1 0 0 0 0 0 0 1 1 1 0 0 0 00 decG1 33 0 00 00
0 1 3 0 3 1 0 0 0 0 0 0 1 1 0 0 0 0 00 decG3Wrap ff 0 00 00
0 1 0 3 0 1 0 0 0 0 0 0 1 1 0 0 0 0 00 clrG0 00 0 00 00
0 1 0 1 0 1 0 0 0 0 0 0 1 1 0 0 0 0 00 incG0Again 01 0 00 00
0 0 0 0 0 1 1 0 2 0 0 0 1 0 0 0 0 0 10 ldPC 10 0 00 10
0 0 0 0 0 1 1 1 2 1 1 0 1 0 0 0 0 0 40 ldAR 40 0 00 40
0 0 0 0 0 1 1 2 2 2 2 0 1 0 0 0 0 0 80 ldSP 80 0 00 80
0 0 0 0 0 1 1 0 1 0 0 0 1 0 0 0 0 0 00 incPC 11 0 00 11
0 0 0 0 0 1 1 2 0 2 2 0 1 0 0 0 0 0 00 decSP 7f 0 00 7f
0 0 0 0 0 1 1 0 3 0 0 0 1 0 0 0 0 0 00 clrPC 00 0 00 00
0 0 0 0 0 1 0 0 0 3 3 0 1 0 0 0 0 0 00 addrSel3 00 0 00 00
0 0 0 0 3 0 0 0 0 0 0 0 1 1 4 1 0 0 00 addCarry 00 c 00 00
0 0 0 0 0 1 0 0 0 0 0 0 1 1 4 0 0 0 00 flagHold 34 c 00 00
0 0 0 0 0 1 0 0 0 0 0 0 1 1 5 0 0 0 00 addcIn 35 c 00 00
0 0 0 0 0 1 0 0 0 0 0 0 1 1 5 1 0 0 00 addcFlag 34 0 00 00
0 0 0 0 2 0 0 0 0 0 0 0 1 1 4 1 0 0 00 addOvf 80 3 00 00
0 0 0 0 1 0 0 0 0 0 0 0 1 1 6 1 0 0 00 sub 32 0 00 00
0 0 0 0 0 1 0 0 0 0 0 0 1 1 6 1 0 0 00 subBorrow ce 6 00 00
0 0 0 0 1 2 0 0 0 0 0 0 1 1 7 1 0 0 00 and 33 4 00 00
0 0 0 0 1 1 0 0 0 0 0 0 1 1 9 1 0 0 00 xorZero 00 c 00 00
0 0 0 0 0 0 0 0 0 0 0 0 1 1 3 1 0 0 00 notB fe 6 00 00
0 0 0 0 2 1 0 0 0 0 0 0 1 1 a 1 0 0 00 lsl fe 2 00 00
0 0 0 0 0 1 0 0 0 0 0 0 1 1 b 1 0 0 00 lsr 00 c 00 00
0 0 0 0 1 1 0 0 0 0 0 0 1 1 e 0 0 0 00 rolcHold 67 c 00 00
0 0 0 0 0 1 0 0 0 0 0 0 1 1 f 1 0 0 00 rorc 80 6 00 00
0 0 0 0 3 1 0 0 0 0 0 0 1 1 d 1 0 0 00 asr ff 6 00 00
0 0 0 0 2 1 0 0 0 0 0 0 1 1 c 1 0 0 00 aslOvf fe 7 00 00
0 0 0 0 0 1 0 0 0 0 1 0 1 1 1 0 1 0 00 storeAR 33 7 00 40
0 0 0 0 0 1 0 0 0 0 1 0 1 1 1 0 0 1 00 loadAR 33 7 33 40
0 0 0 0 3 1 0 0 0 0 2 0 1 1 0 0 1 0 00 storeSP ff 7 00 7f
0 1 0 2 0 1 0 0 0 0 2 1 1 1 0 0 0 1 00 ldMemG0 ff 7 ff 7f
1 0 0 0 0 1 0 0 0 0 1 0 1 1 0 0 0 0 00 resetMid 00 0 00 00
0 0 0 0 3 1 0 0 0 0 2 0 1 1 0 0 0 0 00 afterReset 00 0 00 00

//--- testbench/tb_aluSystem.sv
// Datapath testbench
`timescale 1ns/1ps

module tb_aluSystem;

    localparam int MaxSteps = 64; // golden lines kept

    typedef struct packed {
        logic [datapathPkg::DataWidth-1:0] alu;
        aluPkg::aluFlags_t                 flags;
        logic [datapathPkg::DataWidth-1:0] mem;
        logic [datapathPkg::AddrWidth-1:0] addr;
    } expVal_t;

    logic                              CLK;
    logic                              rstN_i;
    datapathPkg::microOp_t             op_i;
    logic [datapathPkg::DataWidth-1:0] aluOut;
    aluPkg::aluFlags_t                 flags;
    logic [datapathPkg::DataWidth-1:0] memOut;
    logic [datapathPkg::AddrWidth-1:0] addrOut;

    datapathPkg::microOp_t opStep   [MaxSteps]; // per-line micro-op
    expVal_t               expStep  [MaxSteps];
    logic                  rstStep  [MaxSteps]; // reset held during the line
    logic [8*16-1:0]       nameStep [MaxSteps];
    int                    numSteps;
    int                    errors;
    int                    passed;
    logic                  loaded;

    aluSystem u_dut (
        .CLK      (CLK),
        .rstN_i   (rstN_i),
        .op_i     (op_i),
        .aluOut_o (aluOut),
        .flags_o  (flags),
        .memOut_o (memOut),
        .addr_o   (addrOut)
    );

    function automatic datapathPkg::bankCtrl_t makeCtrl(input logic [7:0] we, sel, fun, rdA, rdB);
        datapathPkg::bankCtrl_t c;
        c.wrEn   = we[0];
        c.wrSel  = sel[1:0];
        c.fun    = datapathPkg::regFun_t'(fun[1:0]);
        c.rdSelA = rdA[1:0]; // port C in address bank
        c.rdSelB = rdB[1:0]; // port D in address bank
        return c;
    endfunction

    function automatic int checkByte(input logic [8*16-1:0] name, input string what,
                                     input logic [7:0] expv, input logic [7:0] act);
        if (act !== expv) begin
            $display("mismatch %0s %0s: expected %h, actual %h", name, what, expv, act);
            return 1;
        end
        return 0;
    endfunction

    task automatic readGolden();
        int                    fd;
        int                    n;
        string                 line;
        logic [7:0]            f [19]; // micro-op columns
        logic [7:0]            e [4];  // expected columns
        logic [8*16-1:0]       name;
        datapathPkg::microOp_t op;
        fd = $fopen("testbench/aluSystem_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file testbench/aluSystem_golden.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && numSteps < MaxSteps) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 4 || line.substr(0, 1) == "//") begin
                continue; // blank or comment
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], name,
                        e[0], e[1], e[2], e[3]);
            if (n != 24) begin
                $display("golden line after test %0d has missing or unreadable columns", numSteps);
                errors++;
                continue;
            end
            op.gp   = makeCtrl(f[1], f[2], f[3], f[4], f[5]);
            op.addr = makeCtrl(f[6], f[7], f[8], f[9], f[10]);
            op.srcA   = datapathPkg::srcASel_t'(f[11][1:0]);
            op.srcB   = datapathPkg::srcBSel_t'(f[12][1:0]);
            op.aluA   = f[13][0];
            op.aluFun = aluPkg::aluFun_t'(f[14][3:0]);
            op.flagEn = f[15][0];
            op.memWr  = f[16][0];
            op.memRd  = f[17][0];
            op.imm    = f[18];
            rstStep[numSteps]  = f[0][0];
            opStep[numSteps]   = op;
            nameStep[numSteps] = name;
            expStep[numSteps]  = {e[0], e[1][3:0], e[2], e[3]};
            numSteps++;
        end
        $fclose(fd);
        if (numSteps == 0) begin
            $display("the golden file holds no test lines");
            errors++;
        end
    endtask

    task automatic runStep(input int i);
        datapathPkg::microOp_t op;
        int                    bad;
        op = opStep[i];
        if (!op.gp.wrEn && !op.addr.wrEn) begin
            op.imm = 8'($urandom); // no register takes imm on this line
        end
        @(negedge CLK);
        rstN_i = ~rstStep[i];
        op_i   = op;
        @(posedge CLK);
        #4; // just before the next falling edge
        bad = checkByte(nameStep[i], "aluOut", expStep[i].alu, aluOut)
            + checkByte(nameStep[i], "flags", {4'h0, expStep[i].flags}, {4'h0, flags})
            + checkByte(nameStep[i], "memOut", expStep[i].mem, memOut)
            + checkByte(nameStep[i], "addr", expStep[i].addr, addrOut);
        errors += bad;
        if (bad == 0) begin
            passed++;
            $display("ok   %0s", nameStep[i]);
        end else begin
            $display("bad  %0s (%0d wrong outputs)", nameStep[i], bad);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK; // 10 ns period
    end

    initial begin
        errors   = 0;
        passed   = 0;
        numSteps = 0;
        loaded   = 1'b0;
        rstN_i   = 1'b0;
        op_i     = '0;
        void'($urandom(78));
        readGolden();
        loaded = 1'b1;
        repeat (5) @(posedge CLK); // reset released at the first step
        for (int i = 0; i < numSteps; i++) begin
            runStep(i);
        end
        $display("done: %0d tests, %0d passed, %0d failed, %0d errors",
                 numSteps, passed, numSteps - passed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog scaled by the number of golden lines
    initial begin
        wait (loaded);
        #((numSteps * 10 + 200) * 1ns);
        $display("timeout: the run did not end within %0d ns", numSteps * 10 + 200);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- verilog/alu.sv
// Sixteen-function ALU with flags
`timescale 1ns/1ps

module alu (
    input  logic                                CLK,
    input  logic                                rstN_i,
    input  aluPkg::aluFun_t                     fun_i,
    input  logic                                flagEn_i,
    input  logic [datapathPkg::DataWidth-1:0]   a_i,
    input  logic [datapathPkg::DataWidth-1:0]   b_i,
    output logic [datapathPkg::DataWidth-1:0]   result_o,
    output aluPkg::aluFlags_t                   flags_o
);

    aluPkg::aluFlags_t                  flagsQ;   // registered ZCNO
    logic [datapathPkg::DataWidth:0]    addWide;  // sum with carry out
    logic [datapathPkg::DataWidth:0]    subWide;  // difference with borrow
    logic                               carryAdd; // carry into adder
    logic                               aMsb;
    logic                               bMsb;
    logic                               rMsb;
    logic                               cNext;    // carry produced this cycle
    logic                               cDef;     // function defines carry
    logic                               oNext;

    assign aMsb = a_i[datapathPkg::DataWidth-1];
    assign bMsb = b_i[datapathPkg::DataWidth-1];
    assign rMsb = result_o[datapathPkg::DataWidth-1];

    // addc takes the stored carry, add takes none
    assign carryAdd = (fun_i == aluPkg::aluAddc) & flagsQ.carry;
    assign addWide  = {1'b0, a_i} + {1'b0, b_i}
                    + {{datapathPkg::DataWidth{1'b0}}, carryAdd};
    assign subWide  = {1'b0, a_i} - {1'b0, b_i};

    always_comb begin
        cNext = 1'b0;
        cDef  = 1'b0;
        case (fun_i)
            aluPkg::aluPassA: result_o = a_i;
            aluPkg::aluPassB: result_o = b_i;
            aluPkg::aluNotA:  result_o = ~a_i;
            aluPkg::aluNotB:  result_o = ~b_i;
            aluPkg::aluAdd, aluPkg::aluAddc: begin
                result_o = addWide[datapathPkg::DataWidth-1:0];
                cNext    = addWide[datapathPkg::DataWidth];
                cDef     = 1'b1;
            end
            aluPkg::aluSub: begin
                result_o = subWide[datapathPkg::DataWidth-1:0];
                cNext    = subWide[datapathPkg::DataWidth]; // set on borrow
                cDef     = 1'b1;
            end
            aluPkg::aluAnd:   result_o = a_i & b_i;
            aluPkg::aluOr:    result_o = a_i | b_i;
            aluPkg::aluXor:   result_o = a_i ^ b_i;
            aluPkg::aluLsl: begin
                result_o = a_i << 1;
                cNext    = aMsb; // bit shifted out
                cDef     = 1'b1;
            end
            aluPkg::aluLsr: begin
                result_o = a_i >> 1;
                cNext    = a_i[0];
                cDef     = 1'b1;
            end
            aluPkg::aluAsl:   result_o = a_i << 1;              // carry kept
            aluPkg::aluAsr:   result_o = {aMsb, a_i[datapathPkg::DataWidth-1:1]};
            aluPkg::aluRolc: begin
                result_o = {a_i[datapathPkg::DataWidth-2:0], flagsQ.carry};
                cNext    = aMsb;
                cDef     = 1'b1;
            end
            default: begin // rorc
                result_o = {flagsQ.carry, a_i[datapathPkg::DataWidth-1:1]};
                cNext    = a_i[0];
                cDef     = 1'b1;
            end
        endcase
    end

    // signed overflow, cleared for functions that do not define it
    always_comb begin
        case (fun_i)
            aluPkg::aluAdd, aluPkg::aluAddc: oNext = (aMsb == bMsb) && (rMsb != aMsb);
            aluPkg::aluSub:                  oNext = (aMsb != bMsb) && (rMsb != aMsb);
            aluPkg::aluAsl:                  oNext = (rMsb != aMsb); // sign changed
            default:                         oNext = 1'b0;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            flagsQ <= '0;
        end else if (flagEn_i) begin
            flagsQ.zero     <= (result_o == '0);
            flagsQ.negative <= rMsb;
            flagsQ.overflow <= oNext;
            if (cDef) begin
                flagsQ.carry <= cNext;
            end
        end
    end

    assign flags_o = flagsQ;

endmodule

//--- verilog/aluPkg.sv
// ALU function and flag definitions
package aluPkg;

    localparam int AluFunWidth = 4; // sixteen functions

    typedef enum logic [AluFunWidth-1:0] {
        aluPassA = 4'h0,
        aluPassB = 4'h1,
        aluNotA  = 4'h2,
        aluNotB  = 4'h3,
        aluAdd   = 4'h4,
        aluAddc  = 4'h5, // add with registered carry
        aluSub   = 4'h6, // carry means borrow
        aluAnd   = 4'h7,
        aluOr    = 4'h8,
        aluXor   = 4'h9,
        aluLsl   = 4'hA,
        aluLsr   = 4'hB,
        aluAsl   = 4'hC,
        aluAsr   = 4'hD,
        aluRolc  = 4'hE, // rotate left through carry
        aluRorc  = 4'hF  // rotate right through carry
    } aluFun_t;

    // Z bit 3, C bit 2, N bit 1, O bit 0
    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
        logic overflow;
    } aluFlags_t;

endpackage

//--- verilog/aluSystem.sv
// Processor datapath top level
`timescale 1ns/1ps

module aluSystem (
    input  logic                                CLK,
    input  logic                                rstN_i,
    input  datapathPkg::microOp_t               op_i,
    output logic [datapathPkg::DataWidth-1:0]   aluOut_o,
    output aluPkg::aluFlags_t                   flags_o,
    output logic [datapathPkg::DataWidth-1:0]   memOut_o,
    output logic [datapathPkg::AddrWidth-1:0]   addr_o
);

    logic [datapathPkg::DataWidth-1:0] gpWrData;   // source A mux
    logic [datapathPkg::DataWidth-1:0] addrWrData; // source B mux
    logic [datapathPkg::DataWidth-1:0] gpA;
    logic [datapathPkg::DataWidth-1:0] gpB;
    logic [datapathPkg::DataWidth-1:0] addrC;
    logic [datapathPkg::DataWidth-1:0] addrD;      // memory address
    logic [datapathPkg::DataWidth-1:0] aluOpA;
    logic [datapathPkg::DataWidth-1:0] aluResult;
    logic [datapathPkg::DataWidth-1:0] memData;

    always_comb begin
        case (op_i.srcA)
            datapathPkg::srcAImm:   gpWrData = op_i.imm;
            datapathPkg::srcAMem:   gpWrData = memData;
            datapathPkg::srcAAddrC: gpWrData = addrC;
            default:                gpWrData = aluResult;
        endcase
    end

    always_comb begin
        case (op_i.srcB)
            datapathPkg::srcBMem: addrWrData = memData;
            datapathPkg::srcBAlu: addrWrData = aluResult;
            default:              addrWrData = op_i.imm; // also code 0
        endcase
    end

    assign aluOpA = op_i.aluA ? gpA : addrC; // operand B is always gpB

    regBank #(.NumRegs(datapathPkg::NumGpRegs)) gpBank (
        .CLK      (CLK),
        .rstN_i   (rstN_i),
        .ctrl_i   (op_i.gp),
        .wrData_i (gpWrData),
        .rdA_o    (gpA),
        .rdB_o    (gpB)
    );

    // PC, AR, SP at selects 0 to 2
    regBank #(.NumRegs(datapathPkg::NumAddrRegs)) addrBank (
        .CLK      (CLK),
        .rstN_i   (rstN_i),
        .ctrl_i   (op_i.addr),
        .wrData_i (addrWrData),
        .rdA_o    (addrC),
        .rdB_o    (addrD)
    );

    alu aluUnit (
        .CLK      (CLK),
        .rstN_i   (rstN_i),
        .fun_i    (op_i.aluFun),
        .flagEn_i (op_i.flagEn),
        .a_i      (aluOpA),
        .b_i      (gpB),
        .result_o (aluResult),
        .flags_o  (flags_o)
    );

    dataMemory dataMem (
        .CLK      (CLK),
        .addr_i   (addrD),
        .wrData_i (aluResult), // stores take the ALU result
        .wr_i     (op_i.memWr),
        .rd_i     (op_i.memRd),
        .rdData_o (memData)
    );

    assign aluOut_o = aluResult;
    assign memOut_o = memData;
    assign addr_o   = addrD;

endmodule

//--- verilog/dataMemory.sv
// Byte-wide data memory
`timescale 1ns/1ps

module dataMemory (
    input  logic                                CLK,
    input  logic [datapathPkg::AddrWidth-1:0]   addr_i,
    input  logic [datapathPkg::DataWidth-1:0]   wrData_i,
    input  logic                                wr_i,
    input  logic                                rd_i,
    output logic [datapathPkg::DataWidth-1:0]   rdData_o
);

    logic [datapathPkg::DataWidth-1:0] mem [2**datapathPkg::AddrWidth]; // 256 bytes

    always_ff @(posedge CLK) begin
        if (wr_i) begin
            mem[addr_i] <= wrData_i; // store at edge
        end
    end

    // read is combinational, zero when not reading
    assign rdData_o = rd_i ? mem[addr_i] : '0;

endmodule

//--- verilog/datapathPkg.sv
// Datapath control definitions
package datapathPkg;

    localparam int DataWidth   = 8; // datapath word
    localparam int AddrWidth   = 8; // data memory address
    localparam int NumGpRegs   = 4; // general bank
    localparam int NumAddrRegs = 3; // PC, AR, SP
    localparam int RegSelWidth = 2; // read and write selects

    typedef enum logic [1:0] {
        regDec  = 2'd0,
        regInc  = 2'd1,
        regLoad = 2'd2,
        regClr  = 2'd3
    } regFun_t;

    typedef enum logic [1:0] {
        srcAImm   = 2'd0, // immediate byte of the micro-op
        srcAMem   = 2'd1, // memory read data
        srcAAddrC = 2'd2, // address bank port C
        srcAAlu   = 2'd3  // ALU result
    } srcASel_t;

    // code 0 is unused here, the top level treats it as immediate
    typedef enum logic [1:0] {
        srcBImm = 2'd1,
        srcBMem = 2'd2,
        srcBAlu = 2'd3
    } srcBSel_t;

    typedef struct packed {
        logic                   wrEn;   // apply fun to wrSel
        logic [RegSelWidth-1:0] wrSel;
        regFun_t                fun;
        logic [RegSelWidth-1:0] rdSelA; // port A, or C in address bank
        logic [RegSelWidth-1:0] rdSelB; // port B, or D in address bank
    } bankCtrl_t;

    typedef struct packed {
        bankCtrl_t            gp;     // general bank
        bankCtrl_t            addr;   // address bank
        srcASel_t             srcA;   // general bank input
        srcBSel_t             srcB;   // address bank input
        logic                 aluA;   // 1 general port A, 0 address port C
        aluPkg::aluFun_t      aluFun;
        logic                 flagEn;
        logic                 memWr;
        logic                 memRd;
        logic [DataWidth-1:0] imm;
    } microOp_t;

endpackage

//--- verilog/regBank.sv
// Counting register bank
`timescale 1ns/1ps

module regBank #(
    parameter int NumRegs = 4
) (
    input  logic                                CLK,
    input  logic                                rstN_i,
    input  datapathPkg::bankCtrl_t              ctrl_i,
    input  logic [datapathPkg::DataWidth-1:0]   wrData_i,
    output logic [datapathPkg::DataWidth-1:0]   rdA_o,
    output logic [datapathPkg::DataWidth-1:0]   rdB_o
);

    logic [datapathPkg::DataWidth-1:0] regs [NumRegs]; // register contents

    // only the selected register moves
    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl_i.wrEn) begin
            for (int i = 0; i < NumRegs; i++) begin
                if (ctrl_i.wrSel == i[datapathPkg::RegSelWidth-1:0]) begin
                    case (ctrl_i.fun)
                        datapathPkg::regDec:  regs[i] <= regs[i] - 1'b1; // wraps at zero
                        datapathPkg::regInc:  regs[i] <= regs[i] + 1'b1;
                        datapathPkg::regLoad: regs[i] <= wrData_i;
                        default:              regs[i] <= '0;             // clear
                    endcase
                end
            end
        end
    end

    // read ports, a select past the last register gives zero
    always_comb begin
        rdA_o = '0;
        rdB_o = '0;
        for (int i = 0; i < NumRegs; i++) begin
            if (ctrl_i.rdSelA == i[datapathPkg::RegSelWidth-1:0]) begin
                rdA_o = regs[i];
            end
            if (ctrl_i.rdSelB == i[datapathPkg::RegSelWidth-1:0]) begin
                rdB_o = regs[i];
            end
        end
    end

endmodule
